/* common/bus_pkg.sv */
// register bus request type
// register address map
// version and threshold defaults
package bus_pkg;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
    } bus_req_t;

    typedef enum logic [2:0] {
        reg_ctrl  = 3'd0, // write soft reset, read version
        reg_af    = 3'd1,
        reg_ae    = 3'd2,
        reg_rderr = 3'd3,
        reg_size0 = 3'd4, // read takes size snapshot
        reg_size1 = 3'd5,
        reg_size2 = 3'd6,
        reg_rsvd  = 3'd7
    } reg_addr_e;

    localparam logic [7:0] fifo_version = 8'd2;
    localparam int almost_full_pct  = 95; // percent of 255
    localparam int almost_empty_pct = 5;

endpackage

/* common/sram_pkg.sv */
// SRAM ring size and widths
// SRAM pin bundle
// read machine states
package sram_pkg;

    localparam int sram_depth = 64; // ring size in halfwords
    localparam int sram_aw    = 20;
    localparam int sram_dw    = 16;
    localparam int cnt_w      = 21; // halfword fill level

    typedef struct packed {
        logic [sram_aw-1:0] addr;
        logic [sram_dw-1:0] dq_out;
        logic               dq_oe;  // drive data bus
        logic               oe_b;
        logic               we_b;
    } sram_pins_t;

    typedef enum logic [1:0] {
        rd_try  = 2'd0, // wait for data
        rd_read = 2'd1, // SRAM read cycle
        rd_hold = 2'd2  // halfword handed to byte port
    } rd_state_e;

endpackage

/* hw/sram_fifo/fifo_regs.sv */
// register decode and soft reset
// threshold registers
// byte count snapshot and registered read mux
module fifo_regs import bus_pkg::*; import sram_pkg::*; (
    input  logic             BUS_CLK,
    input  logic             RST,
    input  bus_req_t         bus_req,
    output logic [7:0]       bus_data_out,
    output logic             soft_rst,
    output logic [7:0]       almost_full_val,
    output logic [7:0]       almost_empty_val,
    input  logic [cnt_w-1:0] fill_level,
    input  logic [7:0]       read_errors
);
    reg_addr_e      sel;
    logic           in_range;
    logic [cnt_w:0] size_byte;
    logic [cnt_w:0] size_snap;

    assign sel       = reg_addr_e'(bus_req.addr[2:0]);
    assign in_range  = (bus_req.addr[15:3] == '0);
    assign soft_rst  = bus_req.wr && in_range && (sel == reg_ctrl);
    assign size_byte = {fill_level, 1'b0}; // halfwords to bytes

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            almost_full_val  <= 8'(255 * almost_full_pct / 100);
            almost_empty_val <= 8'(255 * almost_empty_pct / 100);
        end else if (bus_req.wr && in_range) begin
            case (sel)
                reg_af:  almost_full_val  <= bus_req.data;
                reg_ae:  almost_empty_val <= bus_req.data;
                default: ;
            endcase
        end
    end

    // upper bytes come from the copy taken when the low byte is read
    always_ff @(posedge BUS_CLK) begin
        if (bus_req.rd && in_range && (sel == reg_size0))
            size_snap <= size_byte;
    end

    always_ff @(posedge BUS_CLK) begin
        if (!in_range) begin
            bus_data_out <= '0;
        end else begin
            case (sel)
                reg_ctrl:  bus_data_out <= fifo_version;
                reg_af:    bus_data_out <= almost_full_val;
                reg_ae:    bus_data_out <= almost_empty_val;
                reg_rderr: bus_data_out <= read_errors;
                reg_size0: bus_data_out <= size_byte[7:0]; // live value
                reg_size1: bus_data_out <= size_snap[15:8];
                reg_size2: bus_data_out <= 8'(size_snap[cnt_w:16]);
                default:   bus_data_out <= '0;
            endcase
        end
    end

endmodule

/* hw/sram_fifo/input_buffer.sv */
// 16-entry 32-bit synchronous FIFO
// registered occupancy count
module input_buffer (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic        push,
    input  logic [31:0] push_data,
    input  logic        pop,
    output logic [31:0] head,
    output logic        not_empty,
    output logic        full
);
    logic [31:0] mem [16];
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;
    logic [4:0]  count;
    logic        do_push;
    logic        do_pop;

    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = count[4]; // 16 entries

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + 4'(do_push); // wraps naturally
            rd_ptr <= rd_ptr + 4'(do_pop);
            count  <= count + 5'(do_push) - 5'(do_pop);
        end
    end

endmodule

/* hw/sram_fifo/sram_ctrl.sv */
// SRAM ring buffer controller
// write and read pointers, full flag
// read machine with priority over writes
// fill level and near-full hysteresis
module sram_ctrl import sram_pkg::*; (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  logic [31:0]        buf_head,
    input  logic               buf_not_empty,
    output logic               buf_pop,
    output sram_pins_t         sram,
    input  logic [sram_dw-1:0] sram_dq_in,
    input  logic               fetch,
    output logic [15:0]        word,
    output logic               word_load,
    output logic [cnt_w-1:0]   fill_level,
    input  logic [7:0]         almost_full_val,
    input  logic [7:0]         almost_empty_val,
    output logic               fifo_not_empty,
    output logic               fifo_full,
    output logic               fifo_near_full
);
    rd_state_e          state;
    rd_state_e          state_nxt;
    logic [sram_aw-1:0] wr_ptr;
    logic [sram_aw-1:0] rd_ptr;
    logic [sram_aw-1:0] wr_ptr_nxt;
    logic [sram_aw-1:0] rd_ptr_nxt;
    logic               ring_empty;
    logic               rd_cyc;
    logic               wr_cyc;
    logic               held;
    logic [cnt_w-1:0]   ring_cnt;
    logic [cnt_w-1:0]   nf_set_lvl;
    logic [cnt_w-1:0]   nf_clr_lvl;

    function automatic logic [sram_aw-1:0] ptr_inc(input logic [sram_aw-1:0] p);
        return (p == sram_aw'(sram_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ring_empty = (wr_ptr == rd_ptr);
    assign rd_cyc     = (state == rd_read);
    assign wr_cyc     = buf_not_empty && !fifo_full && !rd_cyc; // read wins
    assign buf_pop    = wr_cyc && wr_ptr[0]; // after high half
    assign wr_ptr_nxt = wr_cyc ? ptr_inc(wr_ptr) : wr_ptr;
    assign rd_ptr_nxt = rd_cyc ? ptr_inc(rd_ptr) : rd_ptr;
    assign held       = (state == rd_hold) && !fetch; // halfword sits in byte port

    always_comb begin
        state_nxt = state;
        case (state)
            rd_try: begin
                if (fetch && !ring_empty)
                    state_nxt = rd_read;
            end
            rd_read: state_nxt = rd_hold;
            rd_hold: begin
                if (fetch)
                    state_nxt = ring_empty ? rd_try : rd_read;
            end
            default: state_nxt = rd_try;
        endcase
    end

    always_comb begin
        sram.addr   = rd_cyc ? rd_ptr : wr_ptr;
        sram.dq_out = wr_ptr[0] ? buf_head[31:16] : buf_head[15:0];
        sram.dq_oe  = wr_cyc;
        sram.oe_b   = !rd_cyc;
        sram.we_b   = !wr_cyc;
    end

    always_comb begin
        if (wr_ptr >= rd_ptr)
            ring_cnt = cnt_w'(wr_ptr - rd_ptr);
        else
            ring_cnt = cnt_w'(wr_ptr + sram_aw'(sram_depth) - rd_ptr);
    end

    assign nf_set_lvl = cnt_w'((int'(almost_full_val) + 1) * sram_depth / 256);
    assign nf_clr_lvl = cnt_w'((int'(almost_empty_val) + 1) * sram_depth / 256);

    always_ff @(posedge BUS_CLK) begin
        if (rd_cyc)
            word <= sram_dq_in;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state          <= rd_try;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_full      <= 1'b0;
            word_load      <= 1'b0;
            fill_level     <= '0;
            fifo_near_full <= 1'b0;
        end else begin
            state      <= state_nxt;
            wr_ptr     <= wr_ptr_nxt;
            rd_ptr     <= rd_ptr_nxt;
            fifo_full  <= (ptr_inc(wr_ptr_nxt) == rd_ptr_nxt); // depth-1 halfwords
            word_load  <= rd_cyc;
            fill_level <= ring_cnt + cnt_w'(held);
            if (fill_level >= nf_set_lvl)
                fifo_near_full <= 1'b1;
            else if (fill_level <= nf_clr_lvl || fill_level == '0)
                fifo_near_full <= 1'b0;
        end
    end

    assign fifo_not_empty = !ring_empty;

endmodule

/* hw/sram_fifo/usb_byte_out.sv */
// byte port holding one fetched halfword
// low byte first, then high byte
// saturating read-error counter
module usb_byte_out (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] word,
    input  logic        word_load,
    output logic        fetch,
    input  logic        usb_read,
    output logic        usb_valid,
    output logic [7:0]  usb_data,
    output logic [7:0]  read_errors,
    output logic        fifo_read_error
);
    logic [15:0] word_q;
    logic        byte_sel; // 1 selects high byte

    assign fetch           = !usb_valid && !word_load; // no request while one is in flight
    assign usb_data        = byte_sel ? word_q[15:8] : word_q[7:0];
    assign fifo_read_error = (read_errors != '0);

    always_ff @(posedge BUS_CLK) begin
        if (word_load)
            word_q <= word;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            usb_valid   <= 1'b0;
            byte_sel    <= 1'b0;
            read_errors <= '0;
        end else begin
            if (word_load) begin
                usb_valid <= 1'b1;
                byte_sel  <= 1'b0;
            end else if (usb_read && usb_valid) begin
                usb_valid <= !byte_sel; // empty after high byte
                byte_sel  <= !byte_sel;
            end
            if (usb_read && !usb_valid && read_errors != 8'hff)
                read_errors <= read_errors + 8'd1;
        end
    end

endmodule

/* hw/sram_fifo_top.sv */
// SRAM FIFO top level
// register block, input buffer, SRAM controller, byte port
// combined hard and soft reset
module sram_fifo_top import bus_pkg::*; import sram_pkg::*; (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  bus_req_t           bus_req,
    output logic [7:0]         bus_data_out,
    output logic               fifo_read_next,
    input  logic               fifo_empty_in,
    input  logic [31:0]        fifo_data,
    output sram_pins_t         sram,
    input  logic [sram_dw-1:0] sram_dq_in,
    input  logic               usb_read,
    output logic               usb_valid,
    output logic [7:0]         usb_data,
    output logic               fifo_not_empty,
    output logic               fifo_full,
    output logic               fifo_near_full,
    output logic               fifo_read_error
);
    logic             soft_rst;
    logic             blk_rst;
    logic             buf_full;
    logic             buf_pop;
    logic             buf_not_empty;
    logic [31:0]      buf_head;
    logic             fetch;
    logic [15:0]      word;
    logic             word_load;
    logic [cnt_w-1:0] fill_level;
    logic [7:0]       almost_full_val;
    logic [7:0]       almost_empty_val;
    logic [7:0]       read_errors;

    assign blk_rst        = RST | soft_rst;
    assign fifo_read_next = !buf_full; // back-pressure upstream

    fifo_regs regs_i (
        .BUS_CLK, .RST(blk_rst), .bus_req, .bus_data_out, .soft_rst,
        .almost_full_val, .almost_empty_val, .fill_level, .read_errors
    );

    input_buffer ibuf_i (
        .BUS_CLK, .RST(blk_rst), .push(!fifo_empty_in && fifo_read_next),
        .push_data(fifo_data), .pop(buf_pop), .head(buf_head),
        .not_empty(buf_not_empty), .full(buf_full)
    );

    sram_ctrl ctrl_i (
        .BUS_CLK, .RST(blk_rst), .buf_head, .buf_not_empty, .buf_pop, .sram,
        .sram_dq_in, .fetch, .word, .word_load, .fill_level, .almost_full_val,
        .almost_empty_val, .fifo_not_empty, .fifo_full, .fifo_near_full
    );

    usb_byte_out usb_i (
        .BUS_CLK, .RST(blk_rst), .word, .word_load, .fetch, .usb_read,
        .usb_valid, .usb_data, .read_errors, .fifo_read_error
    );

endmodule

/* test/sram_model.sv */
// behavioral asynchronous 16-bit SRAM
// combinational read of the current address
// write on every clock where write enable is low
module sram_model import sram_pkg::*; (
    input  logic               BUS_CLK,
    input  sram_pins_t         sram,
    output logic [sram_dw-1:0] dq
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [sram_dw-1:0] mem [2**sram_aw];

    initial begin
        for (int a = 0; a < 2**sram_aw; a++)
            mem[a] = 16'(a) ^ 16'(a >> 4) ^ 16'h5a5a; // unwritten cells differ per address
    end

    always @(posedge BUS_CLK) begin
        if (!sram.we_b)
            mem[sram.addr] <= sram.dq_out;
    end

    assign dq = mem[sram.addr];

endmodule

/* test/sram_fifo_chk.sv */
// concurrent assertions on SRAM strobes and FIFO status
// bound into the SRAM controller
module sram_fifo_chk import sram_pkg::*; (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  sram_pins_t sram,
    input  logic       fifo_full,
    input  logic       fifo_not_empty
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0; // read by the testbench at the end

    strobe_excl: assert property (@(posedge BUS_CLK) disable iff (RST)
        sram.we_b || sram.oe_b)
        else begin
            $error("write enable and output enable active together");
            fails++;
        end

    full_not_empty: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(fifo_full && !fifo_not_empty))
        else begin
            $error("full flag set while the ring is empty");
            fails++;
        end

    drive_on_write: assert property (@(posedge BUS_CLK) disable iff (RST)
        sram.dq_oe == !sram.we_b)
        else begin
            $error("data output enable does not follow write enable");
            fails++;
        end

endmodule

bind sram_ctrl sram_fifo_chk chk_i (.BUS_CLK, .RST, .sram, .fifo_full, .fifo_not_empty);

/* test/tb_sram_fifo.sv */
// testbench for the SRAM FIFO
// register checks, byte stream from an LCG word table
// fill to full, drain, watchdog and result line
module tb_sram_fifo import bus_pkg::*; import sram_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_words = 56; // 8 for the size test, 48 for the fill test
    localparam int watchdog_cycles = n_words * 4 * 40 + 2000;
    localparam logic [7:0] af_default = 8'd242;
    localparam logic [7:0] ae_default = 8'd12;

    logic        BUS_CLK = 1'b0;
    logic        RST;
    bus_req_t    bus_req;
    logic [7:0]  bus_data_out;
    logic        fifo_read_next;
    logic        fifo_empty_in;
    logic [31:0] fifo_data;
    sram_pins_t  sram_pins;
    logic [15:0] sram_dq;
    logic        usb_read;
    logic        usb_valid;
    logic [7:0]  usb_data;
    logic        fifo_not_empty;
    logic        fifo_full;
    logic        fifo_near_full;
    logic        fifo_read_error;
    logic [31:0] word_tbl [n_words];
    logic [7:0]  exp_bytes [n_words * 4];
    int          value_errs = 0;

    sram_fifo_top dut_i (
        .BUS_CLK, .RST, .bus_req, .bus_data_out, .fifo_read_next, .fifo_empty_in,
        .fifo_data, .sram(sram_pins), .sram_dq_in(sram_dq), .usb_read, .usb_valid,
        .usb_data, .fifo_not_empty, .fifo_full, .fifo_near_full, .fifo_read_error
    );

    sram_model sram_i (.BUS_CLK, .sram(sram_pins), .dq(sram_dq));

    always #5 BUS_CLK = ~BUS_CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic bus_write(input reg_addr_e a, input logic [7:0] d);
        @(negedge BUS_CLK);
        bus_req = '{addr: 16'(a), data: d, rd: 1'b0, wr: 1'b1};
        @(negedge BUS_CLK);
        bus_req = '0;
    endtask

    task automatic bus_read(input reg_addr_e a, output logic [7:0] d);
        @(negedge BUS_CLK);
        bus_req = '{addr: 16'(a), data: 8'h00, rd: 1'b1, wr: 1'b0};
        @(negedge BUS_CLK);
        bus_req = '0;
        d = bus_data_out; // registered, one cycle after the address
    endtask

    task automatic check_reg(input reg_addr_e a, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(a, got);
        check_val($sformatf("bus_data_out[%s]", a.name()), got, exp);
    endtask

    task automatic read_size(output int size);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        bus_read(reg_size0, b0);
        bus_read(reg_size1, b1);
        bus_read(reg_size2, b2);
        size = int'({b2, b1, b0});
    endtask

    task automatic push_words(input int first, input int n);
        int idx;
        idx = first;
        while (idx < first + n) begin
            @(negedge BUS_CLK);
            fifo_data     = word_tbl[idx];
            fifo_empty_in = 1'b0;
            if (fifo_read_next)
                idx++; // taken at the next rising edge
        end
        @(negedge BUS_CLK);
        fifo_empty_in = 1'b1;
    endtask

    task automatic pop_bytes(input int first, input int n);
        int taken;
        taken = 0;
        while (taken < n) begin
            @(negedge BUS_CLK);
            usb_read = 1'b0;
            if (usb_valid) begin
                check_val("usb_data", usb_data, exp_bytes[first + taken]);
                usb_read = 1'b1;
                taken++;
            end
        end
        @(negedge BUS_CLK);
        usb_read = 1'b0;
    endtask

    // no SRAM writes for a few cycles and a halfword parked in the byte port
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge BUS_CLK);
            quiet = (sram_pins.we_b && usb_valid) ? quiet + 1 : 0;
        end
    endtask

    initial begin
        #(watchdog_cycles * 10);
        $display("timeout: the test sequence did not finish in %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        int          size;
        int          chk_errs;
        seed = 32'd84;
        for (int i = 0; i < n_words; i++) begin
            seed = lcg_next(seed);
            word_tbl[i] = seed;
            for (int k = 0; k < 4; k++)
                exp_bytes[4 * i + k] = seed[8 * k +: 8]; // low byte first
        end
        RST           = 1'b1;
        bus_req       = '0;
        fifo_empty_in = 1'b1;
        fifo_data     = '0;
        usb_read      = 1'b0;
        repeat (4) @(negedge BUS_CLK);
        RST = 1'b0;

        check_reg(reg_ctrl, 8'd2);
        check_reg(reg_af, af_default);
        check_reg(reg_ae, ae_default);
        check_val("fifo_not_empty", fifo_not_empty, 0);
        check_val("fifo_full", fifo_full, 0);
        check_val("fifo_near_full", fifo_near_full, 0);
        check_val("usb_valid", usb_valid, 0);

        for (int i = 0; i < 3; i++) begin
            @(negedge BUS_CLK);
            check_val("usb_valid", usb_valid, 0);
            usb_read = 1'b1;
            @(negedge BUS_CLK);
            usb_read = 1'b0;
        end
        check_reg(reg_rderr, 8'd3);
        check_val("fifo_read_error", fifo_read_error, 1);

        bus_write(reg_af, 8'h80);
        check_reg(reg_af, 8'h80);
        bus_write(reg_ctrl, 8'h00); // soft reset
        check_reg(reg_af, af_default);
        check_reg(reg_ae, ae_default);
        check_reg(reg_rderr, 8'd0);
        check_val("fifo_read_error", fifo_read_error, 0);

        push_words(0, 8);
        wait_idle();
        read_size(size);
        check_val("byte count", size, 32);
        pop_bytes(0, 32);
        repeat (2) @(negedge BUS_CLK); // fill level is registered
        read_size(size);
        check_val("byte count", size, 0);
        check_val("fifo_not_empty", fifo_not_empty, 0);

        // 32 words reach ring and byte port, 16 stay in the input buffer
        push_words(8, 48);
        wait_idle();
        check_val("fifo_full", fifo_full, 1);
        check_val("fifo_read_next", fifo_read_next, 0);
        check_val("fifo_near_full", fifo_near_full, 1);
        read_size(size);
        check_val("byte count", size, 128);
        pop_bytes(32, 192);
        repeat (2) @(negedge BUS_CLK);
        read_size(size);
        check_val("byte count", size, 0);
        check_val("fifo_near_full", fifo_near_full, 0);
        check_val("fifo_not_empty", fifo_not_empty, 0);

        chk_errs = dut_i.ctrl_i.chk_i.fails;
        $display("checks done: %0d value errors, %0d assertion failures", value_errs, chk_errs);
        if (value_errs == 0 && chk_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* all.f */
common/bus_pkg.sv
common/sram_pkg.sv
hw/sram_fifo/fifo_regs.sv
hw/sram_fifo/input_buffer.sv
hw/sram_fifo/sram_ctrl.sv
hw/sram_fifo/usb_byte_out.sv
hw/sram_fifo_top.sv
test/sram_model.sv
test/sram_fifo_chk.sv
test/tb_sram_fifo.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= all.f
TB_TOP    ?= tb_sram_fifo
RTL_TOP   ?= sram_fifo_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall
PASS_MSG  ?= SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
